// File: chroni_pkg.sv
package chroni_pkg;

   // video mode codes
   localparam logic [1:0] vga_mode_640x480 = 2'd0;
   localparam logic [1:0] vga_mode_800x600 = 2'd1;

   // 640x480, playfield fills the active area
   localparam logic [11:0] mode1_h_total      = 12'd800;
   localparam logic [11:0] mode1_h_sync_pulse = 12'd96;
   localparam logic [11:0] mode1_h_de_start   = 12'd144;
   localparam logic [11:0] mode1_h_de_end     = 12'd784;
   localparam logic [11:0] mode1_h_pf_start   = 12'd144;
   localparam logic [11:0] mode1_h_pf_end     = 12'd784;

   localparam logic [11:0] mode1_v_total      = 12'd525;
   localparam logic [11:0] mode1_v_sync_pulse = 12'd2;
   localparam logic [11:0] mode1_v_de_start   = 12'd35;
   localparam logic [11:0] mode1_v_de_end     = 12'd515;
   localparam logic [11:0] mode1_v_pf_start   = 12'd35;
   localparam logic [11:0] mode1_v_pf_end     = 12'd515;

   // active low syncs
   localparam logic mode1_h_sync_p = 1'b0;
   localparam logic mode1_v_sync_p = 1'b0;

   // 800x600, playfield centred inside the border
   localparam logic [11:0] mode2_h_total      = 12'd1056;
   localparam logic [11:0] mode2_h_sync_pulse = 12'd128;
   localparam logic [11:0] mode2_h_de_start   = 12'd216;
   localparam logic [11:0] mode2_h_de_end     = 12'd1016;
   localparam logic [11:0] mode2_h_pf_start   = 12'd296;
   localparam logic [11:0] mode2_h_pf_end     = 12'd936;

   localparam logic [11:0] mode2_v_total      = 12'd628;
   localparam logic [11:0] mode2_v_sync_pulse = 12'd4;
   localparam logic [11:0] mode2_v_de_start   = 12'd27;
   localparam logic [11:0] mode2_v_de_end     = 12'd627;
   localparam logic [11:0] mode2_v_pf_start   = 12'd87;
   localparam logic [11:0] mode2_v_pf_end     = 12'd567;

   // active high syncs
   localparam logic mode2_h_sync_p = 1'b1;
   localparam logic mode2_v_sync_p = 1'b1;

   // text screen layout
   localparam int          text_cols   = 80;
   localparam logic [12:0] text_base   = 13'd1025;
   localparam int          line_pixels = 640;

   // rgb565 colours
   localparam logic [15:0] border_color          = 16'h10A3;
   localparam logic [15:0] text_background_color = 16'h29AC;
   localparam logic [15:0] text_foreground_color = 16'hF75B;

   // text fetch state machine
   localparam logic [2:0] fetch_idle      = 3'd0;
   localparam logic [2:0] fetch_text_req  = 3'd1;
   localparam logic [2:0] fetch_text_wait = 3'd2;
   localparam logic [2:0] fetch_font_req  = 3'd3;
   localparam logic [2:0] fetch_font_wait = 3'd4;

endpackage

// File: chroni_vga_timing.sv
`timescale 1ns/100ps

module chroni_vga_timing
   import chroni_pkg::*;
(
   input  logic       vga_clk,
   input  logic       reset_n,
   input  logic [1:0] mode_in,
   output logic       hsync_raw,
   output logic       vsync_raw,
   output logic       h_sync_p,
   output logic       v_sync_p,
   output logic       de,
   output logic       pf,
   output logic       pf_pix,
   output logic       line_start,
   output logic       pf_active_next,
   output logic [8:0] scan_row
);

   logic [11:0] h_total;
   logic [11:0] h_sync_pulse;
   logic [11:0] h_de_start;
   logic [11:0] h_de_end;
   logic [11:0] h_pf_start;
   logic [11:0] h_pf_end;
   logic [11:0] v_total;
   logic [11:0] v_sync_pulse;
   logic [11:0] v_de_start;
   logic [11:0] v_de_end;
   logic [11:0] v_pf_start;
   logic [11:0] v_pf_end;

   logic [11:0] x_cnt;
   logic [11:0] y_cnt;
   logic [11:0] y_next;
   logic        frame_start;
   logic [1:0]  mode_sel;
   logic        h_de;
   logic        v_de;
   logic        h_pf;
   logic        v_pf;
   logic        h_pf_pix;

   assign frame_start = (x_cnt == 12'd1) && (y_cnt == 12'd1);
   assign y_next      = (y_cnt == v_total) ? 12'd1 : y_cnt + 12'd1;
   // reset falls back to 640x480
   assign mode_sel    = reset_n ? mode_in : vga_mode_640x480;

   // timing set only changes at frame start
   always_ff @(posedge vga_clk) begin
      if (!reset_n || frame_start) begin
         if (mode_sel == vga_mode_800x600) begin
            h_total      <= mode2_h_total;
            h_sync_pulse <= mode2_h_sync_pulse;
            h_de_start   <= mode2_h_de_start;
            h_de_end     <= mode2_h_de_end;
            h_pf_start   <= mode2_h_pf_start;
            h_pf_end     <= mode2_h_pf_end;
            v_total      <= mode2_v_total;
            v_sync_pulse <= mode2_v_sync_pulse;
            v_de_start   <= mode2_v_de_start;
            v_de_end     <= mode2_v_de_end;
            v_pf_start   <= mode2_v_pf_start;
            v_pf_end     <= mode2_v_pf_end;
            h_sync_p     <= mode2_h_sync_p;
            v_sync_p     <= mode2_v_sync_p;
         end else begin
            h_total      <= mode1_h_total;
            h_sync_pulse <= mode1_h_sync_pulse;
            h_de_start   <= mode1_h_de_start;
            h_de_end     <= mode1_h_de_end;
            h_pf_start   <= mode1_h_pf_start;
            h_pf_end     <= mode1_h_pf_end;
            v_total      <= mode1_v_total;
            v_sync_pulse <= mode1_v_sync_pulse;
            v_de_start   <= mode1_v_de_start;
            v_de_end     <= mode1_v_de_end;
            v_pf_start   <= mode1_v_pf_start;
            v_pf_end     <= mode1_v_pf_end;
            h_sync_p     <= mode1_h_sync_p;
            v_sync_p     <= mode1_v_sync_p;
         end
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         x_cnt <= 12'd1;
         y_cnt <= 12'd1;
      end else if (x_cnt == h_total) begin
         x_cnt <= 12'd1;
         y_cnt <= y_next;
      end else begin
         x_cnt <= x_cnt + 12'd1;
      end
   end

   // flags trail the counters by one cycle
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         hsync_raw <= 1'b0;
         vsync_raw <= 1'b0;
         h_de      <= 1'b0;
         v_de      <= 1'b0;
         h_pf      <= 1'b0;
         v_pf      <= 1'b0;
         h_pf_pix  <= 1'b0;
      end else begin
         if (x_cnt == 12'd1) hsync_raw <= 1'b1;
         else if (x_cnt == h_sync_pulse + 12'd1) hsync_raw <= 1'b0;

         if (x_cnt == h_de_start + 12'd1) h_de <= 1'b1;
         else if (x_cnt == h_de_end + 12'd1) h_de <= 1'b0;

         if (x_cnt == h_pf_start + 12'd1) h_pf <= 1'b1;
         else if (x_cnt == h_pf_end + 12'd1) h_pf <= 1'b0;

         // one cycle early for the line buffer read
         if (x_cnt == h_pf_start) h_pf_pix <= 1'b1;
         else if (x_cnt == h_pf_end) h_pf_pix <= 1'b0;

         if (y_cnt == 12'd1) vsync_raw <= 1'b1;
         else if (y_cnt == v_sync_pulse + 12'd1) vsync_raw <= 1'b0;

         if (y_cnt == v_de_start + 12'd1) v_de <= 1'b1;
         else if (y_cnt == v_de_end + 12'd1) v_de <= 1'b0;

         if (y_cnt == v_pf_start + 12'd1) v_pf <= 1'b1;
         else if (y_cnt == v_pf_end + 12'd1) v_pf <= 1'b0;
      end
   end

   // line bookkeeping for the fetcher, updated as a new line begins
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         line_start     <= 1'b0;
         scan_row       <= 9'd0;
         pf_active_next <= 1'b0;
      end else begin
         line_start <= (x_cnt == h_total);
         if (x_cnt == h_total) begin
            scan_row       <= 9'(y_next - v_pf_start - 12'd1);
            pf_active_next <= (y_next >= v_pf_start - 12'd1) &&
                              (y_next <= v_pf_end - 12'd2);
         end
      end
   end

   assign de     = h_de & v_de;
   assign pf     = h_pf & v_pf;
   assign pf_pix = h_pf_pix & v_pf;

endmodule

// File: chroni_text_fetch.sv
`timescale 1ns/100ps

module chroni_text_fetch
   import chroni_pkg::*;
(
   input  logic        vga_clk,
   input  logic        reset_n,
   input  logic        line_start,
   input  logic        pf_active_next,
   input  logic [8:0]  scan_row,
   input  logic [7:0]  data,
   input  logic        rd_ack,
   output logic [12:0] addr,
   output logic        rd_req,
   output logic        wr_en,
   output logic        wr_bank,
   output logic [6:0]  wr_byte_addr,
   output logic [7:0]  wr_data
);

   logic [2:0]  state;
   logic [6:0]  col;
   logic        last_col;
   logic        fill_start;
   logic [7:0]  next_pair;
   logic [2:0]  pair;
   logic [12:0] row_offset;
   logic [12:0] text_addr;
   logic [7:0]  text_buf [text_cols];

   // line pair whose scan gets fetched, wraps to pair 0 before the playfield
   assign next_pair  = scan_row[8:1] + 8'd1;
   assign fill_start = line_start && pf_active_next && !scan_row[0];
   assign last_col   = (col == 7'(text_cols - 1));

   // text row times 80
   assign row_offset = {2'b00, next_pair[7:3], 6'b000000} +
                       {4'b0000, next_pair[7:3], 4'b0000};

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         state  <= fetch_idle;
         rd_req <= 1'b0;
         wr_en  <= 1'b0;
         col    <= 7'd0;
      end else begin
         wr_en <= 1'b0;
         if (fill_start) begin
            col    <= 7'd0;
            rd_req <= 1'b0;
            // character codes only on scan 0
            if (next_pair[2:0] == 3'd0) begin
               state <= fetch_text_req;
            end else begin
               state <= fetch_font_req;
            end
         end else begin
            case (state)
               fetch_text_req: begin
                  rd_req <= 1'b1;
                  state  <= fetch_text_wait;
               end
               fetch_text_wait: begin
                  if (rd_ack) begin
                     rd_req <= 1'b0;
                     if (last_col) begin
                        col   <= 7'd0;
                        state <= fetch_font_req;
                     end else begin
                        col   <= col + 7'd1;
                        state <= fetch_text_req;
                     end
                  end
               end
               fetch_font_req: begin
                  rd_req <= 1'b1;
                  state  <= fetch_font_wait;
               end
               fetch_font_wait: begin
                  if (rd_ack) begin
                     rd_req <= 1'b0;
                     wr_en  <= 1'b1;
                     if (last_col) begin
                        state <= fetch_idle;
                     end else begin
                        col   <= col + 7'd1;
                        state <= fetch_font_req;
                     end
                  end
               end
               default: state <= fetch_idle;
            endcase
         end
      end
   end

   // addresses, character store and line buffer write data
   always_ff @(posedge vga_clk) begin
      if (fill_start) begin
         pair      <= next_pair[2:0];
         text_addr <= text_base + row_offset;
      end else if (state == fetch_text_req) begin
         addr      <= text_addr;
         text_addr <= text_addr + 13'd1;
      end else if (state == fetch_font_req) begin
         // character times 8 plus scan
         addr <= {2'b00, text_buf[col], pair};
      end else if (state == fetch_text_wait && rd_ack) begin
         text_buf[col] <= data;
      end else if (state == fetch_font_wait && rd_ack) begin
         wr_bank      <= pair[0];
         wr_byte_addr <= col;
         wr_data      <= data;
      end
   end

endmodule

// File: chroni_line_buffer.sv
`timescale 1ns/100ps

module chroni_line_buffer
   import chroni_pkg::*;
(
   input  logic       vga_clk,
   input  logic       wr_en,
   input  logic       wr_bank,
   input  logic [6:0] wr_byte_addr,
   input  logic [7:0] wr_data,
   input  logic       rd_bank,
   input  logic [9:0] rd_pixel_addr,
   output logic       rd_pixel
);

   logic [7:0] bank_mem [2][line_pixels / 8];
   logic [7:0] rd_byte;
   logic [2:0] bit_sel;

   assign rd_byte = bank_mem[rd_bank][rd_pixel_addr[9:3]];
   // bit 7 is the leftmost pixel
   assign bit_sel = 3'd7 - rd_pixel_addr[2:0];

   always_ff @(posedge vga_clk) begin
      if (wr_en) begin
         bank_mem[wr_bank][wr_byte_addr] <= wr_data;
      end
   end

   always_ff @(posedge vga_clk) begin
      rd_pixel <= rd_byte[bit_sel];
   end

endmodule

// File: chroni_pixel_out.sv
`timescale 1ns/100ps

module chroni_pixel_out
   import chroni_pkg::*;
(
   input  logic       vga_clk,
   input  logic       reset_n,
   input  logic       de,
   input  logic       pf,
   input  logic       pf_pix,
   input  logic       hsync_raw,
   input  logic       vsync_raw,
   input  logic       h_sync_p,
   input  logic       v_sync_p,
   input  logic       line_start,
   input  logic [8:0] scan_row,
   input  logic       rd_pixel,
   output logic       rd_bank,
   output logic [9:0] rd_pixel_addr,
   output logic       hs,
   output logic       vs,
   output logic [4:0] vga_r,
   output logic [5:0] vga_g,
   output logic [4:0] vga_b
);

   logic [15:0] color_q;

   // two display lines per bank
   assign rd_bank = scan_row[1];

   always_ff @(posedge vga_clk) begin
      if (!reset_n || line_start) begin
         rd_pixel_addr <= 10'd0;
      end else if (pf_pix && rd_pixel_addr != 10'(line_pixels - 1)) begin
         rd_pixel_addr <= rd_pixel_addr + 10'd1;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         hs      <= ~h_sync_p;
         vs      <= ~v_sync_p;
         color_q <= 16'h0000;
      end else begin
         hs <= (hsync_raw == h_sync_p);
         vs <= (vsync_raw == v_sync_p);
         if (!de) color_q <= 16'h0000;
         else if (!pf) color_q <= border_color;
         else if (rd_pixel) color_q <= text_foreground_color;
         else color_q <= text_background_color;
      end
   end

   assign vga_r = color_q[15:11];
   assign vga_g = color_q[10:5];
   assign vga_b = color_q[4:0];

endmodule

// File: chroni.sv
`timescale 1ns/100ps

module chroni (
   input  logic        vga_clk,
   input  logic        reset_n,
   input  logic [1:0]  vga_mode_in,
   input  logic [7:0]  data,
   input  logic        rd_ack,
   output logic        hs,
   output logic        vs,
   output logic [4:0]  vga_r,
   output logic [5:0]  vga_g,
   output logic [4:0]  vga_b,
   output logic [12:0] addr,
   output logic        rd_req
);

   logic       hsync_raw;
   logic       vsync_raw;
   logic       h_sync_p;
   logic       v_sync_p;
   logic       de;
   logic       pf;
   logic       pf_pix;
   logic       line_start;
   logic       pf_active_next;
   logic [8:0] scan_row;
   logic       wr_en;
   logic       wr_bank;
   logic [6:0] wr_byte_addr;
   logic [7:0] wr_data;
   logic       rd_bank;
   logic [9:0] rd_pixel_addr;
   logic       rd_pixel;

   chroni_vga_timing u_timing (
      .vga_clk        (vga_clk),
      .reset_n        (reset_n),
      .mode_in        (vga_mode_in),
      .hsync_raw      (hsync_raw),
      .vsync_raw      (vsync_raw),
      .h_sync_p       (h_sync_p),
      .v_sync_p       (v_sync_p),
      .de             (de),
      .pf             (pf),
      .pf_pix         (pf_pix),
      .line_start     (line_start),
      .pf_active_next (pf_active_next),
      .scan_row       (scan_row)
   );

   chroni_text_fetch u_fetch (
      .vga_clk        (vga_clk),
      .reset_n        (reset_n),
      .line_start     (line_start),
      .pf_active_next (pf_active_next),
      .scan_row       (scan_row),
      .data           (data),
      .rd_ack         (rd_ack),
      .addr           (addr),
      .rd_req         (rd_req),
      .wr_en          (wr_en),
      .wr_bank        (wr_bank),
      .wr_byte_addr   (wr_byte_addr),
      .wr_data        (wr_data)
   );

   chroni_line_buffer u_line_buffer (
      .vga_clk        (vga_clk),
      .wr_en          (wr_en),
      .wr_bank        (wr_bank),
      .wr_byte_addr   (wr_byte_addr),
      .wr_data        (wr_data),
      .rd_bank        (rd_bank),
      .rd_pixel_addr  (rd_pixel_addr),
      .rd_pixel       (rd_pixel)
   );

   chroni_pixel_out u_pixel_out (
      .vga_clk        (vga_clk),
      .reset_n        (reset_n),
      .de             (de),
      .pf             (pf),
      .pf_pix         (pf_pix),
      .hsync_raw      (hsync_raw),
      .vsync_raw      (vsync_raw),
      .h_sync_p       (h_sync_p),
      .v_sync_p       (v_sync_p),
      .line_start     (line_start),
      .scan_row       (scan_row),
      .rd_pixel       (rd_pixel),
      .rd_bank        (rd_bank),
      .rd_pixel_addr  (rd_pixel_addr),
      .hs             (hs),
      .vs             (vs),
      .vga_r          (vga_r),
      .vga_g          (vga_g),
      .vga_b          (vga_b)
   );

endmodule

// File: chroni_tb_mem.sv
`timescale 1ns/100ps

module chroni_tb_mem (
   input  logic        vga_clk,
   input  logic        reset_n,
   input  logic [2:0]  max_delay,
   input  logic [12:0] addr,
   input  logic        rd_req,
   output logic [7:0]  data,
   output logic        rd_ack
);

   logic [7:0] mem [8192];
   logic [7:0] lfsr;
   logic       busy;
   int         wait_left;

   // 8-bit fibonacci lfsr, taps 8 6 5 4
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   // one lfsr step per delay bit
   task automatic draw_delay(output int delay);
      logic [2:0] bits;
      for (int i = 0; i < 3; i++) begin
         lfsr = lfsr_step(lfsr);
         bits = {bits[1:0], lfsr[0]};
      end
      delay = bits % (max_delay + 1);
   endtask

   initial begin
      int off;
      lfsr      = 8'd62;
      busy      = 1'b0;
      wait_left = 0;
      data      = 8'h00;
      rd_ack    = 1'b0;
      for (int a = 0; a < 8192; a++) begin
         off = a - 1025;
         if (a < 1024) begin
            // font byte at character * 8 + scan
            mem[a] = 8'(a) ^ 8'hA5;
         end else if (off >= 0 && off < 2400) begin
            mem[a] = 8'(((off / 80) * 7 + off % 80) % 128);
         end else begin
            mem[a] = 8'(a) ^ 8'(a >> 5);
         end
      end
   end

   // ack and data change on the falling edge
   always @(negedge vga_clk) begin
      if (!reset_n || !rd_req) begin
         busy = 1'b0;
         rd_ack <= 1'b0;
      end else if (rd_ack) begin
         rd_ack <= 1'b0;
      end else begin
         if (!busy) begin
            busy = 1'b1;
            draw_delay(wait_left);
         end
         if (wait_left == 0) begin
            rd_ack <= 1'b1;
            data   <= mem[addr];
            busy = 1'b0;
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

endmodule

// File: chroni_tb.sv
`timescale 1ns/100ps

module chroni_tb
   import chroni_pkg::*;
();

   localparam int num_tests   = 4;
   localparam int num_probes  = 8;
   // largest frame is 800x600
   localparam int max_frame   = 1056 * 628;
   localparam int cycle_limit = (num_tests * 3 + 2) * max_frame;

   logic        vga_clk;
   logic        reset_n;
   logic [1:0]  vga_mode_in;
   logic [2:0]  max_delay;
   logic [7:0]  data;
   logic        rd_ack;
   logic        hs;
   logic        vs;
   logic [4:0]  vga_r;
   logic [5:0]  vga_g;
   logic [4:0]  vga_b;
   logic [12:0] addr;
   logic        rd_req;

   // mode, max ack delay, then eight probe pairs (x, y) from the sync edges
   logic [17:0][11:0] stim [num_tests];

   int          h_total;
   int          h_sync;
   int          h_de_start;
   int          h_de_end;
   int          h_pf_start;
   int          h_pf_end;
   int          v_total;
   int          v_sync;
   int          v_de_start;
   int          v_de_end;
   int          v_pf_start;
   int          v_pf_end;
   logic        sync_pol;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic        last_req = 1'b0;
   logic        last_ack = 1'b0;
   logic [12:0] last_addr = 13'd0;

   chroni u_chroni (
      .vga_clk     (vga_clk),
      .reset_n     (reset_n),
      .vga_mode_in (vga_mode_in),
      .data        (data),
      .rd_ack      (rd_ack),
      .hs          (hs),
      .vs          (vs),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .addr        (addr),
      .rd_req      (rd_req)
   );

   chroni_tb_mem u_chroni_tb_mem (
      .vga_clk   (vga_clk),
      .reset_n   (reset_n),
      .max_delay (max_delay),
      .addr      (addr),
      .rd_req    (rd_req),
      .data      (data),
      .rd_ack    (rd_ack)
   );

   initial begin
      vga_clk = 1'b0;
      forever #4 vga_clk = ~vga_clk;
   end

   task automatic check_value(input string name, input int expected, input int actual);
      checks++;
      assert (actual == expected) else begin
         $display("FAIL %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic load_timing(input logic [1:0] mode);
      if (mode == vga_mode_800x600) begin
         h_total    = 1056;
         h_sync     = 128;
         h_de_start = 216;
         h_de_end   = 1016;
         h_pf_start = 296;
         h_pf_end   = 936;
         v_total    = 628;
         v_sync     = 4;
         v_de_start = 27;
         v_de_end   = 627;
         v_pf_start = 87;
         v_pf_end   = 567;
         sync_pol   = 1'b1;
      end else begin
         h_total    = 800;
         h_sync     = 96;
         h_de_start = 144;
         h_de_end   = 784;
         h_pf_start = 144;
         h_pf_end   = 784;
         v_total    = 525;
         v_sync     = 2;
         v_de_start = 35;
         v_de_end   = 515;
         v_pf_start = 35;
         v_pf_end   = 515;
         sync_pol   = 1'b0;
      end
   endtask

   // colour at an output position, from the memory fill rule
   function automatic logic [15:0] expected_color(input int x, input int y);
      int         pix;
      int         disp_line;
      int         ch;
      logic [7:0] font;
      if (x < h_de_start || x >= h_de_end || y < v_de_start || y >= v_de_end) begin
         return 16'h0000;
      end
      if (x < h_pf_start || x >= h_pf_end || y < v_pf_start || y >= v_pf_end) begin
         return border_color;
      end
      pix       = x - h_pf_start;
      disp_line = y - v_pf_start;
      // 16 display lines per text row, each scan shown twice
      ch   = ((disp_line / 16) * 7 + pix / 8) % 128;
      font = 8'((ch * 8 + (disp_line / 2) % 8) ^ 8'hA5);
      return font[7 - pix % 8] ? text_foreground_color : text_background_color;
   endfunction

   task automatic wait_frame_start();
      logic prev_vs;
      logic found;
      found   = 1'b0;
      prev_vs = (vs == sync_pol);
      while (!found) begin
         @(negedge vga_clk);
         found   = (vs == sync_pol) && !prev_vs;
         prev_vs = (vs == sync_pol);
      end
   endtask

   // walks one frame from a vs leading edge to the next
   task automatic scan_frame(input int row);
      int   x_off;
      int   y_off;
      int   hs_run;
      int   vs_run;
      int   bad_period;
      int   bad_width;
      logic prev_hs;
      logic prev_vs;
      logic cur_hs;
      logic cur_vs;
      logic done;
      x_off      = 0;
      y_off      = 0;
      hs_run     = 0;
      vs_run     = 0;
      bad_period = -1;
      bad_width  = -1;
      prev_hs    = 1'b1;
      prev_vs    = 1'b1;
      done       = 1'b0;
      while (!done) begin
         for (int k = 0; k < num_probes; k++) begin
            if (x_off == stim[row][15 - 2 * k] && y_off == stim[row][14 - 2 * k]) begin
               check_value("vga_rgb", expected_color(x_off, y_off), {vga_r, vga_g, vga_b});
            end
         end
         if (hs == sync_pol) hs_run++;
         if (vs == sync_pol) vs_run++;
         @(negedge vga_clk);
         cur_hs = (hs == sync_pol);
         cur_vs = (vs == sync_pol);
         if (cur_hs && !prev_hs) begin
            if (x_off + 1 != h_total && bad_period < 0) bad_period = x_off + 1;
            if (hs_run != h_sync && bad_width < 0) bad_width = hs_run;
            hs_run = 0;
            x_off  = 0;
            y_off++;
         end else begin
            x_off++;
         end
         done    = cur_vs && !prev_vs;
         prev_hs = cur_hs;
         prev_vs = cur_vs;
      end
      check_value("hs period", h_total, (bad_period < 0) ? h_total : bad_period);
      check_value("hs pulse", h_sync, (bad_width < 0) ? h_sync : bad_width);
      check_value("vs period", v_total, y_off);
      check_value("vs pulse", v_sync * h_total, vs_run);
   endtask

   initial begin
      int row_errors;
      reset_n     = 1'b0;
      vga_mode_in = vga_mode_640x480;
      max_delay   = 3'd0;
      stim[0] = {12'd0, 12'd2, 12'd144, 12'd35, 12'd783, 12'd514, 12'd400, 12'd200,
                 12'd151, 12'd36, 12'd620, 12'd470, 12'd10, 12'd100, 12'd300, 12'd520,
                 12'd143, 12'd35};
      stim[1] = {12'd1, 12'd0, 12'd216, 12'd27, 12'd1015, 12'd626, 12'd296, 12'd87,
                 12'd935, 12'd566, 12'd600, 12'd300, 12'd250, 12'd300, 12'd100, 12'd50,
                 12'd500, 12'd5};
      stim[2] = {12'd1, 12'd7, 12'd297, 12'd95, 12'd700, 12'd400, 12'd400, 12'd566,
                 12'd930, 12'd90, 12'd215, 12'd300, 12'd1016, 12'd300, 12'd600, 12'd86,
                 12'd600, 12'd567};
      stim[3] = {12'd0, 12'd7, 12'd160, 12'd50, 12'd783, 12'd35, 12'd144, 12'd514,
                 12'd300, 12'd250, 12'd700, 12'd100, 12'd784, 12'd200, 12'd200, 12'd34,
                 12'd450, 12'd515};
      load_timing(vga_mode_in);
      repeat (3) @(negedge vga_clk);
      reset_n = 1'b1;
      for (int row = 0; row < num_tests; row++) begin
         row_errors  = errors;
         vga_mode_in = stim[row][17][1:0];
         max_delay   = stim[row][16][2:0];
         load_timing(vga_mode_in);
         wait_frame_start();
         wait_frame_start();
         scan_frame(row);
         $display("test %0d: mode %s, max ack delay %0d, %0d errors", row,
                  (vga_mode_in == vga_mode_800x600) ? "800x600" : "640x480",
                  max_delay, errors - row_errors);
      end
      $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // rd_req has to stay up until rd_ack is seen, with a steady address
   always @(posedge vga_clk) begin
      if (reset_n) begin
         assert (rd_req || !last_req || last_ack) else begin
            $display("%0t: rd_req dropped before rd_ack was seen", $time);
            errors++;
         end
         if (rd_req && last_req && !last_ack) begin
            check_value("addr", last_addr, addr);
         end
      end
      last_req  <= rd_req;
      last_ack  <= rd_ack;
      last_addr <= addr;
   end

   always @(posedge vga_clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
         $display("TEST FAIL");
         $finish;
      end
   end

endmodule

// File: chroni.f
chroni_pkg.sv
chroni_vga_timing.sv
chroni_text_fetch.sv
chroni_line_buffer.sv
chroni_pixel_out.sv
chroni.sv
chroni_tb_mem.sv
chroni_tb.sv
